// File: sim.f
+incdir+design
+incdir+verif
design/board_pkg.sv
design/display_pkg.sv
design/input_decode.sv
design/drop_control.sv
design/pixel_mapper.sv
design/piece_pos.sv
verif/piece_pos_tb.sv

// File: verif/piece_pos_ref.svh
`ifndef PIECE_POS_REF_SVH
`define PIECE_POS_REF_SVH

// Game state as seen from the button side, one update per step
phase_t  m_phase;
col_t    m_cursor;
row_t    m_row;
height_t m_heights [1:`NUM_COLS];
player_t m_player;
dir_t    m_dir_prev;	// Inputs of the previous step
logic    m_down_prev;

function automatic void model_reset();
	m_phase     = phase_idle;
	m_cursor    = '0;
	m_row       = '0;
	m_player    = 1'b1;	// Yellow starts
	m_dir_prev  = dir_none;
	m_down_prev = 1'b0;
	for (int i = 1; i <= `NUM_COLS; i++)
		m_heights[i] = '0;
endfunction

function automatic void model_step(input dir_t dir, input logic dn);
	logic moved_right;
	logic moved_left;
	logic pressed;
	logic released;
	moved_right = (m_dir_prev == dir_none) && (dir == dir_right);
	moved_left  = (m_dir_prev == dir_none) && (dir == dir_left);
	pressed     = dn && !m_down_prev;
	released    = !dn && m_down_prev;
	m_dir_prev  = dir;
	m_down_prev = dn;
	case (m_phase)
		phase_idle:
		begin
			if (moved_right)
			begin
				m_cursor = `NUM_COLS;
				m_phase  = phase_aim;
			end
			else if (moved_left)
			begin
				m_cursor = 1;
				m_phase  = phase_aim;
			end
		end
		phase_aim:
		begin
			if (pressed && m_heights[m_cursor] < `NUM_ROWS)
			begin
				m_row   = `NUM_ROWS - m_heights[m_cursor];
				m_phase = phase_drop;
			end
			else if (moved_right && m_cursor < `NUM_COLS)
				m_cursor = m_cursor + 1;
			else if (moved_left && m_cursor > 1)
				m_cursor = m_cursor - 1;
		end
		default:
		begin
			if (released)
			begin
				m_heights[m_cursor] = m_heights[m_cursor] + 1;
				m_player = ~m_player;
				m_phase  = phase_idle;
				m_cursor = '0;
				m_row    = '0;
			end
		end
	endcase
endfunction

// Expected top level outputs for the current model state
function automatic void model_outputs(output pixel_t ex, output pixel_t ey,
	output colour_t ec, output logic ecl, output player_t ep, output col_t ecol,
	output row_t erow);
	ex  = `IDLE_X;
	ey  = `IDLE_Y;
	ecl = 1'b1;
	if (m_phase != phase_idle)
		ex = `COL_X0 + `COL_STEP * (m_cursor - 1);
	if (m_phase == phase_aim)
		ey = `AIM_Y;
	if (m_phase == phase_drop)
	begin
		ey  = `BOTTOM_Y - `ROW_STEP * (`NUM_ROWS - m_row);	// Row 6 is the bottom
		ecl = 1'b0;
	end
	ec   = m_player ? `COLOUR_YELLOW : `COLOUR_RED;
	ep   = m_player;
	ecol = m_cursor;
	erow = m_row;
endfunction

`endif

// File: verif/piece_pos_tb.sv
`timescale 1ns/1ns

`include "board_config.svh"

module piece_pos_tb
	import board_pkg::*;
	import display_pkg::*;
();

	localparam int STEPS_CURSOR   = 24;
	localparam int STEPS_DROP     = 4;
	localparam int STEPS_STACK    = 26;
	localparam int STEPS_RANDOM   = 200;
	localparam int STEPS_TOTAL    = STEPS_CURSOR + STEPS_DROP + STEPS_STACK + STEPS_RANDOM;
	localparam int TIMEOUT_CYCLES = STEPS_TOTAL * 20 + 200;

	logic    clk;
	logic    rst;
	dir_t    direction;
	logic    down;
	pixel_t  x;
	pixel_t  y;
	colour_t colour;
	logic    clear;
	player_t player;
	col_t    col;
	row_t    row;

	int          checks;
	int          errors;
	int          test_start;	// Error count when the current test began
	logic [31:0] seed;
	event        check_ev;
	event        check_done;

	`include "piece_pos_ref.svh"

	piece_pos dut0 (
		.clk       (clk),
		.rst       (rst),
		.direction (direction),
		.down      (down),
		.x         (x),
		.y         (y),
		.colour    (colour),
		.clear     (clear),
		.player    (player),
		.col       (col),
		.row       (row)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [7:0] got,
		input logic [7:0] want);
		checks++;
		assert (got === want)
		else
		begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, want);
		end
	endtask

	// Outputs settle three edges after the inputs are sampled
	task automatic settle_and_check();
		repeat (6) @(posedge clk);
		@(negedge clk);
		-> check_ev;
		@(check_done);
	endtask

	task automatic apply_step(input dir_t d, input logic dn);
		@(posedge clk);
		direction <= d;
		down      <= dn;
		model_step(d, dn);
		settle_and_check();
	endtask

	task automatic end_test(input string name);
		$display("Test %-8s %s, %0d errors", name,
			(errors == test_start) ? "ok" : "failed", errors - test_start);
		test_start = errors;
	endtask

	always
	begin : compare
		pixel_t  exp_x;
		pixel_t  exp_y;
		colour_t exp_colour;
		logic    exp_clear;
		player_t exp_player;
		col_t    exp_col;
		row_t    exp_row;
		@(check_ev);
		model_outputs(exp_x, exp_y, exp_colour, exp_clear, exp_player, exp_col, exp_row);
		check_value("x", x, exp_x);
		check_value("y", y, exp_y);
		check_value("colour", colour, exp_colour);
		check_value("clear", clear, exp_clear);
		check_value("player", player, exp_player);
		check_value("col", col, exp_col);
		check_value("row", row, exp_row);
		-> check_done;
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles, the stimulus never finished", TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		clk        = 1'b0;
		rst        = 1'b0;
		direction  = dir_none;
		down       = 1'b0;
		checks     = 0;
		errors     = 0;
		test_start = 0;
		model_reset();
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		settle_and_check();
		end_test("reset");

		apply_step(dir_right, 1'b0);	// Enter at column 7
		apply_step(dir_none, 1'b0);
		apply_step(dir_right, 1'b0);	// Right edge
		apply_step(dir_none, 1'b0);
		apply_step(dir_left, 1'b0);
		apply_step(dir_left, 1'b0);	// Held
		apply_step(dir_none, 1'b0);
		apply_step(dir_t'(2'b11), 1'b0);	// Not a direction
		apply_step(dir_none, 1'b0);
		repeat (6)
		begin
			apply_step(dir_left, 1'b0);
			apply_step(dir_none, 1'b0);
		end
		apply_step(dir_right, 1'b0);
		apply_step(dir_right, 1'b0);	// Held
		apply_step(dir_none, 1'b0);
		end_test("cursor");

		apply_step(dir_none, 1'b1);
		apply_step(dir_none, 1'b0);
		apply_step(dir_left, 1'b0);	// Enter at column 1
		apply_step(dir_none, 1'b0);
		end_test("drop");

		repeat (6)
		begin
			apply_step(dir_none, 1'b1);
			apply_step(dir_none, 1'b0);
			apply_step(dir_left, 1'b0);
			apply_step(dir_none, 1'b0);
		end
		apply_step(dir_none, 1'b1);	// Column 1 is full now
		apply_step(dir_none, 1'b0);
		end_test("stack");

		seed = 32'h3020_d516;
		for (int n = 0; n < STEPS_RANDOM; n++)
		begin
			seed = lcg_next(seed);
			if (seed[31:29] < 3'd3)
				apply_step(direction, ~down);
			else
				apply_step(dir_t'(seed[25:24]), down);
		end
		end_test("random");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: design/piece_pos.sv
`timescale 1ns/1ns

module piece_pos
	import board_pkg::*;
	import display_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  dir_t    direction,
	input  logic    down,
	output pixel_t  x,
	output pixel_t  y,
	output colour_t colour,
	output logic    clear,
	output player_t player,
	output col_t    col,
	output row_t    row
);

	// Button events, one cycle each
	logic right_press;
	logic left_press;
	logic down_press;
	logic down_release;

	phase_t  phase;
	height_t landed_height;

	input_decode u_input_decode (
		.clk          (clk),
		.rst          (rst),
		.direction    (direction),
		.down         (down),
		.right_press  (right_press),
		.left_press   (left_press),
		.down_press   (down_press),
		.down_release (down_release)
	);

	// Cursor and landed row go straight out as col and row
	drop_control u_drop_control (
		.clk           (clk),
		.rst           (rst),
		.right_press   (right_press),
		.left_press    (left_press),
		.down_press    (down_press),
		.down_release  (down_release),
		.phase         (phase),
		.cursor        (col),
		.landed_row    (row),
		.landed_height (landed_height),
		.player        (player)
	);

	pixel_mapper u_pixel_mapper (
		.clk           (clk),
		.rst           (rst),
		.phase         (phase),
		.cursor        (col),
		.landed_height (landed_height),
		.player        (player),
		.x             (x),
		.y             (y),
		.colour        (colour),
		.clear         (clear)
	);

endmodule

// File: design/pixel_mapper.sv
`timescale 1ns/1ns

`include "board_config.svh"

module pixel_mapper
	import board_pkg::*;
	import display_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  phase_t  phase,
	input  col_t    cursor,
	input  height_t landed_height,
	input  player_t player,
	output pixel_t  x,
	output pixel_t  y,
	output colour_t colour,
	output logic    clear
);

	pixel_t  col_x;
	pixel_t  landed_y;
	pixel_t  x_next;
	pixel_t  y_next;
	colour_t colour_next;
	logic    clear_next;

	// Column 1 sits at COL_X0
	assign col_x    = pixel_t'(`COL_X0 + `COL_STEP * (int'(cursor) - 1));
	assign landed_y = pixel_t'(`BOTTOM_Y - `ROW_STEP * int'(landed_height));

	always_comb
	begin
		case (phase)
			phase_aim:
			begin
				x_next     = col_x;
				y_next     = pixel_t'(`AIM_Y);
				clear_next = 1'b1;
			end

			phase_drop:
			begin
				x_next     = col_x;
				y_next     = landed_y;
				clear_next = 1'b0;	// Piece stays drawn
			end

			default:
			begin
				x_next     = pixel_t'(`IDLE_X);
				y_next     = pixel_t'(`IDLE_Y);
				clear_next = 1'b1;
			end
		endcase
	end

	assign colour_next = (player == player_red) ? `COLOUR_RED : `COLOUR_YELLOW;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			x      <= pixel_t'(`IDLE_X);
			y      <= pixel_t'(`IDLE_Y);
			colour <= `COLOUR_YELLOW;	// Yellow moves first
			clear  <= 1'b1;
		end
		else
		begin
			x      <= x_next;
			y      <= y_next;
			colour <= colour_next;
			clear  <= clear_next;
		end
	end

endmodule

// File: design/drop_control.sv
`timescale 1ns/1ns

`include "board_config.svh"

module drop_control
	import board_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    right_press,
	input  logic    left_press,
	input  logic    down_press,
	input  logic    down_release,
	output phase_t  phase,
	output col_t    cursor,
	output row_t    landed_row,
	output height_t landed_height,
	output player_t player
);

	height_t heights [1:`NUM_COLS];	// Indexed by column number
	height_t col_height;
	logic    col_full;
	logic    start_drop;
	logic    commit;

	// Height under the cursor, nothing to look up while idle
	always_comb
	begin
		if (cursor == '0)
			col_height = '0;
		else
			col_height = heights[cursor];
	end

	assign col_full = (col_height >= `NUM_ROWS);

	assign start_drop = (phase == phase_aim) && down_press && !col_full;
	assign commit     = (phase == phase_drop) && down_release;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			phase         <= phase_idle;
			cursor        <= '0;
			landed_row    <= '0;
			landed_height <= '0;
		end
		else
		begin
			case (phase)
				phase_idle:
				begin
					if (right_press)
					begin
						cursor <= col_t'(`NUM_COLS);	// Enter from the right edge
						phase  <= phase_aim;
					end
					else if (left_press)
					begin
						cursor <= col_t'(1);
						phase  <= phase_aim;
					end
				end

				phase_aim:
				begin
					if (start_drop)
					begin
						// Lowest free cell, counted from the top
						landed_row    <= row_t'(`NUM_ROWS - int'(col_height));
						landed_height <= col_height;
						phase         <= phase_drop;
					end
					else if (right_press)
					begin
						if (cursor < col_t'(`NUM_COLS))
							cursor <= cursor + 1'b1;
					end
					else if (left_press)
					begin
						if (cursor > col_t'(1))
							cursor <= cursor - 1'b1;
					end
				end

				phase_drop:
				begin
					if (commit)
					begin
						phase         <= phase_idle;
						cursor        <= '0;
						landed_row    <= '0;
						landed_height <= '0;
					end
				end

				default:
				begin
					phase         <= phase_idle;
					cursor        <= '0;
					landed_row    <= '0;
					landed_height <= '0;
				end
			endcase
		end
	end

	// Board contents and turn only change when a move is committed
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			player <= player_yellow;
			for (int i = 1; i <= `NUM_COLS; i++)
				heights[i] <= '0;
		end
		else if (commit)
		begin
			heights[cursor] <= col_height + 1'b1;
			player          <= ~player;
		end
	end

endmodule

// File: design/input_decode.sv
`timescale 1ns/1ns

module input_decode
	import board_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  dir_t direction,
	input  logic down,
	output logic right_press,
	output logic left_press,
	output logic down_press,
	output logic down_release
);

	dir_t dir_q;	// Sampled this edge
	dir_t dir_prev;
	logic down_q;
	logic down_prev;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			dir_q     <= dir_none;
			dir_prev  <= dir_none;
			down_q    <= 1'b0;
			down_prev <= 1'b0;
		end
		else
		begin
			dir_q     <= direction;
			dir_prev  <= dir_q;
			down_q    <= down;
			down_prev <= down_q;
		end
	end

	// A move only counts when the stick leaves the centre
	always_comb
	begin
		right_press = 1'b0;
		left_press  = 1'b0;
		if (dir_prev == dir_none)
		begin
			case (dir_q)
				dir_right: right_press = 1'b1;
				dir_left:  left_press  = 1'b1;
				default:
				begin
					right_press = 1'b0;	// 2'b11 or still centred
					left_press  = 1'b0;
				end
			endcase
		end
	end

	assign down_press   = down_q & ~down_prev;
	assign down_release = ~down_q & down_prev;

endmodule

// File: design/display_pkg.sv
package display_pkg;

	// Screen coordinate, x or y
	typedef logic [7:0] pixel_t;

	// One bit each of red, green and blue
	typedef logic [2:0] colour_t;

endpackage

// File: design/board_pkg.sv
package board_pkg;

	`include "board_config.svh"

	// 1 to 7, 0 while idle
	typedef logic [3:0] col_t;

	// 1 is the top row and 6 the bottom, 0 for none
	typedef logic [3:0] row_t;

	// Pieces in one column, 0 up to a full column
	typedef logic [$clog2(`NUM_ROWS + 1) - 1:0] height_t;

	typedef logic player_t;

	localparam player_t player_red    = 1'b0;
	localparam player_t player_yellow = 1'b1;

	typedef enum logic [1:0] {
		phase_idle,
		phase_aim,
		phase_drop	// Piece shown at its landing cell until down is released
	} phase_t;

	// Button encoding, 2'b11 is not a direction
	typedef enum logic [1:0] {
		dir_none  = 2'b00,
		dir_right = 2'b01,
		dir_left  = 2'b10
	} dir_t;

endpackage

// File: design/board_config.svh
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// Board size
`define NUM_COLS 7
`define NUM_ROWS 6

// Cursor row across the top of the board
`define COL_X0   40	// x of column 1
`define COL_STEP 10
`define AIM_Y    20

// Parking spot while nobody is aiming
`define IDLE_X   70
`define IDLE_Y   10

// Landed pieces, counted up from the bottom row
`define BOTTOM_Y 80
`define ROW_STEP 10

// RGB codes for the display
`define COLOUR_RED    3'b100
`define COLOUR_YELLOW 3'b110

`endif
